// ==== issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int unsigned XLEN          = 64;
    localparam int unsigned VLEN          = 39;
    localparam int unsigned REG_ADDR_SIZE = 5;
    localparam int unsigned NR_REGS       = 32;
    localparam int unsigned TRANS_ID_BITS = 3;

    // functional unit an instruction goes to
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        ALU       = 3'd1,
        CTRL_FLOW = 3'd2,
        MULT      = 3'd3,
        LOAD      = 3'd4,
        STORE     = 3'd5,
        CSR       = 3'd6
    } fu_t;

    // reduced operation set, only what the units here need
    typedef enum logic [6:0] {
        ADD        = 7'd0,
        SUB        = 7'd1,
        AND        = 7'd2,
        OR         = 7'd3,
        XOR        = 7'd4,
        SLL        = 7'd5,
        MUL        = 7'd6,
        LD         = 7'd7,
        SD         = 7'd8,
        BEQ        = 7'd9,
        CSR_READ   = 7'd10,
        CSR_WRITE  = 7'd11,
        SFENCE_VMA = 7'd12
    } fu_op_t;

    // ------------------------------------------------------------------
    // structs
    // ------------------------------------------------------------------
    // decoded instruction as offered by the scoreboard
    typedef struct packed {
        logic [VLEN-1:0]          pc;
        logic [TRANS_ID_BITS-1:0] trans_id;
        fu_t                      fu;
        fu_op_t                   op;
        logic [REG_ADDR_SIZE-1:0] rs1;
        logic [REG_ADDR_SIZE-1:0] rs2;
        logic [REG_ADDR_SIZE-1:0] rd;
        logic [XLEN-1:0]          imm;
        logic                     use_imm;
        logic                     use_pc;
        logic                     use_zimm;
        logic                     ex_valid;
    } issue_instr_t;

    // ID/EX payload towards the execute units
    typedef struct packed {
        fu_t                      fu;
        fu_op_t                   op;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [XLEN-1:0]          imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [VLEN-1:0]          pc;
    } fu_data_t;

    // one-cycle start strobes, one per unit
    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } unit_valid_t;

    // one commit write port
    typedef struct packed {
        logic [REG_ADDR_SIZE-1:0] waddr;
        logic [XLEN-1:0]          wdata;
        logic                     we;
    } commit_t;

    // per-register pending writer, NONE when nothing is in flight
    typedef fu_t [NR_REGS-1:0] clobber_t;

endpackage

`default_nettype wire

// ==== int_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module int_regfile #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                                 clk_i,
    input  logic                                                 rst_ni,
    input  logic [1:0][issue_pkg::REG_ADDR_SIZE-1:0]             raddr_i,
    output logic [1:0][issue_pkg::XLEN-1:0]                      rdata_o,
    input  issue_pkg::commit_t [NR_COMMIT_PORTS-1:0]             commit_i
);
    import issue_pkg::*;

    // x0 has no storage, only x1..x31 are kept
    logic [NR_REGS-1:1][XLEN-1:0] regs_q;

    // ------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------
    // ports are walked in order so the highest port hitting a register
    // lands last and wins
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            regs_q <= '0;
        end else begin
            for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                // writes to x0 are dropped
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------
    // purely combinational, a commit shows up one cycle after its edge
    always_comb begin : read_ports
        for (int unsigned r = 0; r < 2; r++) begin
            if (raddr_i[r] == '0) begin
                // hard-wired zero register
                rdata_o[r] = '0;
            end else begin
                rdata_o[r] = regs_q[raddr_i[r]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== operand_hazard.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_hazard #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  issue_pkg::issue_instr_t                  issue_instr_i,
    input  logic                                     issue_valid_i,
    input  issue_pkg::clobber_t                      clobber_i,
    input  logic                                     rs1_fwd_valid_i,
    input  logic                                     rs2_fwd_valid_i,
    input  logic                                     alu_ready_i,
    input  logic                                     lsu_ready_i,
    input  logic                                     mult_pending_i,
    input  issue_pkg::commit_t [NR_COMMIT_PORTS-1:0] commit_i,
    output logic                                     forward_rs1_o,
    output logic                                     forward_rs2_o,
    output logic                                     issue_ack_o
);
    import issue_pkg::*;

    logic rs1_clobbered;
    logic rs2_clobbered;
    logic rs1_fwd_ok;
    logic rs2_fwd_ok;
    logic stall;
    logic fu_busy;
    logic rd_free;

    // ------------------------------------------------------------------
    // source operand availability
    // ------------------------------------------------------------------
    // zimm puts an immediate in the rs1 field, nothing to wait on then
    assign rs1_clobbered = !issue_instr_i.use_zimm && (clobber_i[issue_instr_i.rs1] != NONE);
    assign rs2_clobbered = clobber_i[issue_instr_i.rs2] != NONE;

    // CSR results only come back through the regfile
    // SFENCE_VMA is the one consumer allowed to take them early
    assign rs1_fwd_ok = rs1_fwd_valid_i &&
                        ((clobber_i[issue_instr_i.rs1] != CSR) ||
                         (issue_instr_i.op == SFENCE_VMA));
    assign rs2_fwd_ok = rs2_fwd_valid_i &&
                        ((clobber_i[issue_instr_i.rs2] != CSR) ||
                         (issue_instr_i.op == SFENCE_VMA));

    assign forward_rs1_o = rs1_clobbered && rs1_fwd_ok;
    assign forward_rs2_o = rs2_clobbered && rs2_fwd_ok;

    // any clobbered source that can't be forwarded holds the instruction
    assign stall = (rs1_clobbered && !rs1_fwd_ok) || (rs2_clobbered && !rs2_fwd_ok);

    // ------------------------------------------------------------------
    // unit busy
    // ------------------------------------------------------------------
    always_comb begin : unit_busy
        case (issue_instr_i.fu)
            // fixed latency units share one ready
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = !alu_ready_i;
            LOAD, STORE:               fu_busy = !lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // WAW check
    // ------------------------------------------------------------------
    // rd is free if nobody is pending on it, or the pending write
    // is retiring through a commit port right now
    always_comb begin : waw_check
        rd_free = (clobber_i[issue_instr_i.rd] == NONE);
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
                rd_free = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // issue ack
    // ------------------------------------------------------------------
    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            // regular path, operands ready, unit free, no WAW
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less instrs just flow through
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // a multiply last cycle owns the fixed latency result bus,
        // only another multiply may follow it
        if (mult_pending_i && (issue_instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== operand_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_mux (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  issue_pkg::issue_instr_t           issue_instr_i,
    input  logic [1:0][issue_pkg::XLEN-1:0]   rf_rdata_i,
    input  logic [issue_pkg::XLEN-1:0]        rs1_fwd_i,
    input  logic [issue_pkg::XLEN-1:0]        rs2_fwd_i,
    input  logic                              forward_rs1_i,
    input  logic                              forward_rs2_i,
    output issue_pkg::fu_data_t               fu_data_o
);
    import issue_pkg::*;

    logic [XLEN-1:0] rs1_value;
    logic [XLEN-1:0] rs2_value;
    fu_data_t        fu_data_d;

    // register value, or the scoreboard's copy when it is still in flight
    assign rs1_value = forward_rs1_i ? rs1_fwd_i : rf_rdata_i[0];
    assign rs2_value = forward_rs2_i ? rs2_fwd_i : rf_rdata_i[1];

    // ------------------------------------------------------------------
    // operand select
    // ------------------------------------------------------------------
    always_comb begin : operand_select
        fu_data_d.fu       = issue_instr_i.fu;
        fu_data_d.op       = issue_instr_i.op;
        fu_data_d.trans_id = issue_instr_i.trans_id;
        fu_data_d.pc       = issue_instr_i.pc;
        // store data / branch offset ride in imm
        fu_data_d.imm      = issue_instr_i.imm;

        // operand a, zimm beats pc beats register
        if (issue_instr_i.use_zimm) begin
            // zero extended rs1 index
            fu_data_d.operand_a = {{(XLEN-REG_ADDR_SIZE){1'b0}}, issue_instr_i.rs1};
        end else if (issue_instr_i.use_pc) begin
            // sign extended pc
            fu_data_d.operand_a = {{(XLEN-VLEN){issue_instr_i.pc[VLEN-1]}}, issue_instr_i.pc};
        end else begin
            fu_data_d.operand_a = rs1_value;
        end

        // stores and branches need rs2 in b even with an immediate
        if (issue_instr_i.use_imm &&
            (issue_instr_i.fu != STORE) && (issue_instr_i.fu != CTRL_FLOW)) begin
            fu_data_d.operand_b = issue_instr_i.imm;
        end else begin
            fu_data_d.operand_b = rs2_value;
        end
    end

    // ------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------
    // loaded every cycle, the strobes tell when it matters
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o <= '{fu: NONE, op: ADD, default: '0};
        end else begin
            fu_data_o <= fu_data_d;
        end
    end

endmodule

`default_nettype wire

// ==== unit_dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

module unit_dispatch (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  issue_pkg::fu_t         fu_i,
    input  logic                   ex_valid_i,
    input  logic                   accept_i,
    input  logic                   flush_i,
    output issue_pkg::unit_valid_t unit_valid_o,
    output logic                   mult_pending_o
);
    import issue_pkg::*;

    unit_valid_t unit_valid_d;
    unit_valid_t unit_valid_q;

    // ------------------------------------------------------------------
    // strobe decode
    // ------------------------------------------------------------------
    always_comb begin : strobe_decode
        unit_valid_d = '0;
        // an excepting instr is handed on without starting a unit
        if (accept_i && !ex_valid_i) begin
            case (fu_i)
                ALU:         unit_valid_d.alu    = 1'b1;
                CTRL_FLOW:   unit_valid_d.branch = 1'b1;
                MULT:        unit_valid_d.mult   = 1'b1;
                LOAD, STORE: unit_valid_d.lsu    = 1'b1;
                CSR:         unit_valid_d.csr    = 1'b1;
                // NONE starts nothing
                default:     unit_valid_d        = '0;
            endcase
        end
        // flushed instr must not start a unit with stale operands
        if (flush_i) begin
            unit_valid_d = '0;
        end
    end

    // ------------------------------------------------------------------
    // strobe register
    // ------------------------------------------------------------------
    // cleared each cycle unless a new accept comes in, so one-cycle wide
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            unit_valid_q <= '0;
        end else begin
            unit_valid_q <= unit_valid_d;
        end
    end

    assign unit_valid_o = unit_valid_q;

    // multiply in EX this cycle, hazard logic locks out other units
    assign mult_pending_o = unit_valid_q.mult;

endmodule

`default_nettype wire

// ==== issue_read_operands.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_read_operands #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic                                     flush_i,
    // scoreboard issue port
    input  issue_pkg::issue_instr_t                  issue_instr_i,
    input  logic                                     issue_valid_i,
    output logic                                     issue_ack_o,
    input  issue_pkg::clobber_t                      clobber_i,
    // scoreboard forwarding lookup
    output logic [issue_pkg::REG_ADDR_SIZE-1:0]      rs1_o,
    output logic [issue_pkg::REG_ADDR_SIZE-1:0]      rs2_o,
    input  logic [issue_pkg::XLEN-1:0]               rs1_fwd_i,
    input  logic                                     rs1_fwd_valid_i,
    input  logic [issue_pkg::XLEN-1:0]               rs2_fwd_i,
    input  logic                                     rs2_fwd_valid_i,
    // execute side
    input  logic                                     alu_ready_i,
    input  logic                                     lsu_ready_i,
    input  issue_pkg::commit_t [NR_COMMIT_PORTS-1:0] commit_i,
    output issue_pkg::fu_data_t                      fu_data_o,
    output issue_pkg::unit_valid_t                   unit_valid_o
);
    import issue_pkg::*;

    logic [1:0][REG_ADDR_SIZE-1:0] rf_raddr;
    logic [1:0][XLEN-1:0]          rf_rdata;
    logic                          forward_rs1;
    logic                          forward_rs2;
    logic                          issue_ack;
    logic                          mult_pending;
    logic                          accept;

    // sources go both to the regfile and to the scoreboard lookup
    assign rs1_o    = issue_instr_i.rs1;
    assign rs2_o    = issue_instr_i.rs2;
    assign rf_raddr = {issue_instr_i.rs2, issue_instr_i.rs1};

    assign issue_ack_o = issue_ack;
    // handshake completes on valid and ack together
    assign accept = issue_valid_i && issue_ack;

    // ------------------------------------------------------------------
    // sub-blocks
    // ------------------------------------------------------------------
    int_regfile #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_int_regfile (
        .clk_i    ( clk_i    ),
        .rst_ni   ( rst_ni   ),
        .raddr_i  ( rf_raddr ),
        .rdata_o  ( rf_rdata ),
        .commit_i ( commit_i )
    );

    operand_hazard #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_operand_hazard (
        .issue_instr_i   ( issue_instr_i   ),
        .issue_valid_i   ( issue_valid_i   ),
        .clobber_i       ( clobber_i       ),
        .rs1_fwd_valid_i ( rs1_fwd_valid_i ),
        .rs2_fwd_valid_i ( rs2_fwd_valid_i ),
        .alu_ready_i     ( alu_ready_i     ),
        .lsu_ready_i     ( lsu_ready_i     ),
        .mult_pending_i  ( mult_pending    ),
        .commit_i        ( commit_i        ),
        .forward_rs1_o   ( forward_rs1     ),
        .forward_rs2_o   ( forward_rs2     ),
        .issue_ack_o     ( issue_ack       )
    );

    operand_mux i_operand_mux (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .issue_instr_i ( issue_instr_i ),
        .rf_rdata_i    ( rf_rdata      ),
        .rs1_fwd_i     ( rs1_fwd_i     ),
        .rs2_fwd_i     ( rs2_fwd_i     ),
        .forward_rs1_i ( forward_rs1   ),
        .forward_rs2_i ( forward_rs2   ),
        .fu_data_o     ( fu_data_o     )
    );

    unit_dispatch i_unit_dispatch (
        .clk_i          ( clk_i                  ),
        .rst_ni         ( rst_ni                 ),
        .fu_i           ( issue_instr_i.fu       ),
        .ex_valid_i     ( issue_instr_i.ex_valid ),
        .accept_i       ( accept                 ),
        .flush_i        ( flush_i                ),
        .unit_valid_o   ( unit_valid_o           ),
        .mult_pending_o ( mult_pending           )
    );

endmodule

`default_nettype wire

// ==== tb_issue_read_operands.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_issue_read_operands;
    import issue_pkg::*;

    localparam int unsigned NR_COMMIT_PORTS = 2;
    localparam int unsigned ACK_TIMEOUT     = 20;
    localparam int unsigned NR_FIELDS       = 32;

    logic                                clk_i = 1'b0;
    logic                                rst_ni;
    logic                                flush;
    issue_instr_t                        issue_instr;
    logic                                issue_valid;
    logic                                issue_ack;
    clobber_t                            clobber;
    logic [REG_ADDR_SIZE-1:0]            rs1_idx;
    logic [REG_ADDR_SIZE-1:0]            rs2_idx;
    logic [XLEN-1:0]                     rs1_fwd;
    logic                                rs1_fwd_valid;
    logic [XLEN-1:0]                     rs2_fwd;
    logic                                rs2_fwd_valid;
    logic                                alu_ready;
    logic                                lsu_ready;
    commit_t [NR_COMMIT_PORTS-1:0]       commit;
    fu_data_t                            fu_data;
    unit_valid_t                         unit_valid;

    // bookkeeping
    int unsigned vector_count = 0;
    int unsigned failed_count = 0;
    int unsigned error_count  = 0;
    logic        aborted      = 1'b0;
    // hex fields of one parsed data line in file order
    logic [63:0] fld [NR_FIELDS];

    // 8 ns period
    always #4 clk_i = ~clk_i;

    issue_read_operands #(
        .NR_COMMIT_PORTS ( NR_COMMIT_PORTS )
    ) i_dut (
        .clk_i           ( clk_i         ),
        .rst_ni          ( rst_ni        ),
        .flush_i         ( flush         ),
        .issue_instr_i   ( issue_instr   ),
        .issue_valid_i   ( issue_valid   ),
        .issue_ack_o     ( issue_ack     ),
        .clobber_i       ( clobber       ),
        .rs1_o           ( rs1_idx       ),
        .rs2_o           ( rs2_idx       ),
        .rs1_fwd_i       ( rs1_fwd       ),
        .rs1_fwd_valid_i ( rs1_fwd_valid ),
        .rs2_fwd_i       ( rs2_fwd       ),
        .rs2_fwd_valid_i ( rs2_fwd_valid ),
        .alu_ready_i     ( alu_ready     ),
        .lsu_ready_i     ( lsu_ready     ),
        .commit_i        ( commit        ),
        .fu_data_o       ( fu_data       ),
        .unit_valid_o    ( unit_valid    )
    );

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("ERROR at %0t: vector %0d %s mismatch, got %h, expected %h",
                     $time, vector_count, what, got, expected);
            error_count++;
        end
    endtask

    // ready field 2 picks a random level
    function automatic logic pick_ready(input logic [63:0] field);
        logic [31:0] rnd;
        rnd = $urandom;
        return (field == 64'd2) ? rnd[0] : field[0];
    endfunction

    // drop the rest of a comment line
    task automatic skip_line(input int fd);
        int ch;
        ch = $fgetc(fd);
        while ((ch != 10) && (ch != -1)) begin
            ch = $fgetc(fd);
        end
    endtask

    task automatic read_fields(input int fd, input int unsigned count);
        int code;
        for (int unsigned i = 0; i < count; i++) begin
            code = $fscanf(fd, "%h", fld[i]);
            if (code != 1) begin
                $display("data file ends in the middle of vector line %0d", vector_count + 1);
                aborted = 1'b1;
                return;
            end
        end
    endtask

    // W line gives port, addr and data held for one cycle
    task automatic apply_write(input int fd);
        read_fields(fd, 3);
        if (!aborted) begin
            issue_valid                = 1'b0;
            commit[fld[0][0]].we    = 1'b1;
            commit[fld[0][0]].waddr = fld[1][REG_ADDR_SIZE-1:0];
            commit[fld[0][0]].wdata = fld[2];
            @(negedge clk_i);
            commit = '0;
        end
    endtask

    // ------------------------------------------------------------------
    // one issue vector entered and left on a falling edge
    // ------------------------------------------------------------------
    task automatic run_issue(input int fd);
        int unsigned waited;
        int unsigned errors_before;
        read_fields(fd, NR_FIELDS);
        if (aborted) begin
            return;
        end
        vector_count++;
        errors_before = error_count;
        issue_instr.fu       = fu_t'(fld[0][2:0]);
        issue_instr.op       = fu_op_t'(fld[1][6:0]);
        issue_instr.rs1      = fld[2][REG_ADDR_SIZE-1:0];
        issue_instr.rs2      = fld[3][REG_ADDR_SIZE-1:0];
        issue_instr.rd       = fld[4][REG_ADDR_SIZE-1:0];
        issue_instr.use_imm  = fld[5][0];
        issue_instr.use_pc   = fld[6][0];
        issue_instr.use_zimm = fld[7][0];
        issue_instr.ex_valid = fld[8][0];
        issue_instr.pc       = fld[9][VLEN-1:0];
        issue_instr.imm      = fld[10];
        issue_instr.trans_id = vector_count[TRANS_ID_BITS-1:0];
        // up to three pending writers and NONE elsewhere
        for (int unsigned r = 0; r < NR_REGS; r++) begin
            clobber[r] = NONE;
        end
        for (int unsigned k = 0; k < 3; k++) begin
            clobber[fld[11+2*k][REG_ADDR_SIZE-1:0]] = fu_t'(fld[12+2*k][2:0]);
        end
        // an invalid forward carries junk
        rs1_fwd_valid = fld[17][0];
        rs1_fwd       = fld[17][0] ? fld[18] : {$urandom, $urandom};
        rs2_fwd_valid = fld[19][0];
        rs2_fwd       = fld[19][0] ? fld[20] : {$urandom, $urandom};
        alu_ready     = pick_ready(fld[21]);
        lsu_ready     = pick_ready(fld[22]);
        flush         = fld[23][0];
        commit[1].we    = fld[24][0];
        commit[1].waddr = fld[25][REG_ADDR_SIZE-1:0];
        commit[1].wdata = fld[26];
        issue_valid   = 1'b1;

        // combinational ack is sampled mid low phase
        #2;
        // source indexes go straight out to the scoreboard lookup
        check_value(64'(rs1_idx), fld[2], "rs1 index");
        check_value(64'(rs2_idx), fld[3], "rs2 index");
        if (fld[27][0]) begin
            waited = 0;
            while (!issue_ack && (waited < ACK_TIMEOUT)) begin
                @(negedge clk_i);
                #2;
                waited++;
            end
            if (!issue_ack) begin
                $display("timeout: vector %0d got no issue ack within %0d cycles",
                         vector_count, ACK_TIMEOUT);
                aborted = 1'b1;
                return;
            end
        end else begin
            check_value(64'(issue_ack), 64'd0, "issue ack");
        end

        // ID/EX stage holds the instruction one cycle after the handshake edge
        @(negedge clk_i);
        flush  = 1'b0;
        commit = '0;
        check_value(64'(unit_valid), fld[28], "unit strobe");
        if (fld[27][0]) begin
            check_value(fu_data.operand_a, fld[29], "operand a");
            check_value(fu_data.operand_b, fld[30], "operand b");
            check_value(fu_data.imm, fld[31], "immediate");
            check_value(64'(fu_data.fu), 64'(issue_instr.fu), "unit field");
            check_value(64'(fu_data.op), 64'(issue_instr.op), "operation field");
            check_value(64'(fu_data.trans_id), 64'(issue_instr.trans_id), "trans id");
            check_value(64'(fu_data.pc), 64'(issue_instr.pc), "pc field");
        end
        if (error_count == errors_before) begin
            $display("vector %0d: pass", vector_count);
        end else begin
            $display("vector %0d: FAIL", vector_count);
            failed_count++;
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin : main_sequence
        int          fd;
        int          code;
        logic [7:0]  tag;
        void'($urandom(81622));
        rst_ni        = 1'b0;
        flush         = 1'b0;
        issue_instr   = '0;
        issue_valid   = 1'b0;
        clobber       = '0;
        rs1_fwd       = '0;
        rs1_fwd_valid = 1'b0;
        rs2_fwd       = '0;
        rs2_fwd_valid = 1'b0;
        alu_ready     = 1'b1;
        lsu_ready     = 1'b1;
        commit        = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        fd = $fopen("issue_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open issue_testdata.txt");
            aborted = 1'b1;
        end
        while (!aborted) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                skip_line(fd);
            end else if (tag == "W") begin
                apply_write(fd);
            end else if (tag == "I") begin
                run_issue(fd);
            end else begin
                $display("unknown line kind '%c' in data file", tag);
                aborted = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        issue_valid = 1'b0;
        if (!aborted && (vector_count == 0)) begin
            $display("no issue vectors found in the data file");
        end

        $display("vectors run: %0d, failed: %0d, errors: %0d",
                 vector_count, failed_count, error_count);
        if (aborted || (error_count != 0) || (vector_count == 0)) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== issue_testdata.txt ====
# W port addr data | I fu op rs1 rs2 rd use_imm use_pc use_zimm ex_valid pc imm
#   clob_reg clob_fu (x3) fwd1_valid fwd1 fwd2_valid fwd2 alu_ready lsu_ready flush
#   commit_we commit_addr commit_data exp_ack exp_strobe exp_a exp_b exp_imm
# all hex, ready 2 is random, a forward value with valid 0 is random
# fu 0 none 1 alu 2 branch 3 mult 4 load 5 store 6 csr
# strobe bits from msb alu branch lsu mult csr
W 0 1 11
W 0 2 22
W 1 3 33
W 0 4 1234567890abcdef
W 1 5 55
W 0 0 dead
# register read and x0
I 1 0 1 2 6 0 0 0 0 100 0  0 0 0 0 0 0  0 0 0 0  1 2 0  0 0 0  1 10 11 22 0
I 1 3 0 4 7 0 0 0 0 104 0  0 0 0 0 0 0  0 0 0 0  1 2 0  0 0 0  1 10 0 1234567890abcdef 0
# forwarding and stall
I 1 0 1 3 7 0 0 0 0 108 0  1 1 0 0 0 0  1 aaaa 0 0  1 1 0  0 0 0  1 10 aaaa 33 0
I 1 3 5 2 9 0 0 0 0 10c 0  2 4 0 0 0 0  0 0 1 bbbb  1 1 0  0 0 0  1 10 55 bbbb 0
I 1 0 1 2 8 0 0 0 0 110 0  1 1 0 0 0 0  0 0 0 0  1 1 0  0 0 0  0 0 0 0 0
I 1 0 1 3 8 0 0 0 0 114 0  3 6 0 0 0 0  0 0 1 cccc  1 1 0  0 0 0  0 0 0 0 0
I 6 c 1 2 0 0 0 0 0 118 0  1 6 0 0 0 0  1 dddd 0 0  1 2 0  0 0 0  1 1 dddd 22 0
# WAW and busy units
I 1 0 1 2 6 0 0 0 0 11c 0  6 3 0 0 0 0  0 0 0 0  1 1 0  0 0 0  0 0 0 0 0
I 1 0 1 2 6 0 0 0 0 120 0  6 3 0 0 0 0  0 0 0 0  1 1 0  1 6 66  1 10 11 22 0
I 1 0 1 2 8 0 0 0 0 124 0  0 0 0 0 0 0  0 0 0 0  0 2 0  0 0 0  0 0 0 0 0
I 4 7 4 0 a 1 0 0 0 128 10  0 0 0 0 0 0  0 0 0 0  2 0 0  0 0 0  0 0 0 0 0
# unit strobes, exceptions and NONE
I 4 7 4 0 a 1 0 0 0 12c 10  0 0 0 0 0 0  0 0 0 0  2 1 0  0 0 0  1 4 1234567890abcdef 10 10
I 5 8 1 5 0 1 0 0 0 130 8  0 0 0 0 0 0  0 0 0 0  2 1 0  0 0 0  1 4 11 55 8
I 2 9 2 3 0 1 0 0 0 134 20  0 0 0 0 0 0  0 0 0 0  1 2 0  0 0 0  1 8 22 33 20
I 1 0 1 2 b 0 0 0 1 138 0  1 1 b 1 0 0  0 0 0 0  2 2 0  0 0 0  1 0 11 22 0
I 0 0 3 0 3 0 0 0 0 13c 0  3 6 0 0 0 0  0 0 0 0  2 2 0  0 0 0  1 0 33 0 0
# flush, then pc and zimm operands
I 1 0 2 3 8 0 0 0 0 140 0  0 0 0 0 0 0  0 0 0 0  1 2 1  0 0 0  1 0 22 33 0
I 1 0 1 2 8 1 1 0 0 4000001000 4  0 0 0 0 0 0  0 0 0 0  1 2 0  0 0 0  1 10 ffffffc000001000 4 4
I 2 9 1 2 0 1 1 0 0 200 c  0 0 0 0 0 0  0 0 0 0  1 2 0  0 0 0  1 8 200 22 c
I 6 b 1f 0 0 0 1 1 0 4000000000 300  1f 1 0 0 0 0  0 0 0 0  1 2 0  0 0 0  1 1 1f 0 300
# multiply lockout
I 3 6 1 2 c 0 0 0 0 150 0  0 0 0 0 0 0  0 0 0 0  1 2 0  0 0 0  1 2 11 22 0
I 1 0 3 4 d 0 0 0 0 154 0  0 0 0 0 0 0  0 0 0 0  1 2 0  0 0 0  0 0 0 0 0
I 3 6 4 5 e 0 0 0 0 158 0  0 0 0 0 0 0  0 0 0 0  1 2 0  0 0 0  1 2 1234567890abcdef 55 0
I 3 6 6 1 f 0 0 0 0 15c 0  0 0 0 0 0 0  0 0 0 0  1 2 0  0 0 0  1 2 66 11 0

// ==== files.f ====
issue_pkg.sv
int_regfile.sv
operand_hazard.sv
operand_mux.sv
unit_dispatch.sv
issue_read_operands.sv
tb_issue_read_operands.sv

// ==== Makefile ====
# Verilator flow for the issue and operand read stage
# all variables can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_issue_read_operands
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# run from the project root so the data file is found
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
